// ==== dp_cfg.svh ====
// Datapath configuration macros: word and address widths, I/O port count and base address
`ifndef DP_CFG_SVH
`define DP_CFG_SVH

// ----------------------------------------------------------------------
// Data and address widths
// ----------------------------------------------------------------------

// Width of one data word, shared by memory, ALU and I/O ports
`define DP_WORD_WIDTH 16

// Operand address width; covers memory, the null location and I/O
`define DP_ADDR_WIDTH 6

// ----------------------------------------------------------------------
// I/O port map
// ----------------------------------------------------------------------

// Number of I/O ports, each with its own empty/full flags
`define DP_IO_PORT_COUNT 4

// First I/O address. The ports occupy the top of the address space,
// so addresses 60 to 63 select ports 0 to 3 and 1 to 59 are memory.
// Address 0 is the null location and always reads zero
`define DP_IO_BASE_ADDR 60

`endif

// ==== dp_types_pkg.sv ====
// Data-path vector types for words, operand addresses and per-port masks
`include "dp_cfg.svh"

package dp_types_pkg;

    // ------------------------------------------------------------------
    // Data words
    // ------------------------------------------------------------------

    // One data word as held in memory and carried on the I/O ports
    typedef logic [`DP_WORD_WIDTH-1:0] word_t;

    // ------------------------------------------------------------------
    // Addresses
    // ------------------------------------------------------------------

    // Operand address; the top addresses decode to I/O ports
    typedef logic [`DP_ADDR_WIDTH-1:0] addr_t;

    // ------------------------------------------------------------------
    // Port masks
    // ------------------------------------------------------------------

    // One bit per I/O port, used for the empty/full flags and the
    // read/write enables
    typedef logic [`DP_IO_PORT_COUNT-1:0] port_mask_t;

endpackage

// ==== dp_ctrl_pkg.sv ====
// Control types for the datapath: opcode width and the opcode enum
package dp_ctrl_pkg;

    // ------------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------------

    // Opcode field width in the instruction
    localparam int OPCODE_WIDTH = 3;

    // ALU operations. Arithmetic wraps at the word width, and
    // OP_PASS_A forwards operand A unchanged, which is how loads from
    // a port into memory and moves between locations are done.
    // The two unused encodings produce zero
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADD    = 3'd0,
        OP_SUB    = 3'd1,
        OP_AND    = 3'd2,
        OP_OR     = 3'd3,
        OP_XOR    = 3'd4,
        OP_PASS_A = 3'd5
    } opcode_t;

endpackage

// ==== io_predication.sv ====
// I/O predication that checks the I/O operand flags of each instruction and issues read enables
`include "dp_cfg.svh"

module io_predication
    import dp_types_pkg::*, dp_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  logic       cancel,
    input  opcode_t    opcode,
    input  addr_t      read_addr_a,
    input  addr_t      read_addr_b,
    input  addr_t      write_addr_d,
    input  port_mask_t io_read_ef,
    input  port_mask_t io_write_ef,
    output logic       pred_valid,
    output logic       pred_ready,
    output logic       pred_is_io_a,
    output logic       pred_is_io_b,
    output logic       pred_write_io,
    output opcode_t    pred_opcode,
    output addr_t      pred_read_addr_a,
    output addr_t      pred_read_addr_b,
    output addr_t      pred_write_addr,
    output port_mask_t io_rden
);

    localparam int    PORT_IDX_W = $clog2(`DP_IO_PORT_COUNT);
    localparam addr_t IO_BASE    = addr_t'(`DP_IO_BASE_ADDR);

    // ----------------------------------------------------------------------
    // Address decode and flag check
    // ----------------------------------------------------------------------

    logic                  is_io_a, is_io_b, is_io_d;
    addr_t                 offs_a, offs_b, offs_d;
    logic [PORT_IDX_W-1:0] port_a, port_b, port_d;
    logic                  ok_a, ok_b, ok_d, ready;
    port_mask_t            rden_next;

    assign is_io_a = (read_addr_a >= IO_BASE);
    assign is_io_b = (read_addr_b >= IO_BASE);
    assign is_io_d = (write_addr_d >= IO_BASE);

    // Port number is the offset from the I/O base
    assign offs_a = read_addr_a - IO_BASE;
    assign offs_b = read_addr_b - IO_BASE;
    assign offs_d = write_addr_d - IO_BASE;
    assign port_a = offs_a[PORT_IDX_W-1:0];
    assign port_b = offs_b[PORT_IDX_W-1:0];
    assign port_d = offs_d[PORT_IDX_W-1:0];

    // A memory operand is always ready; an I/O operand needs its flag
    assign ok_a  = !is_io_a || io_read_ef[port_a];
    assign ok_b  = !is_io_b || io_read_ef[port_b];
    assign ok_d  = !is_io_d || io_write_ef[port_d];
    assign ready = instr_valid && !cancel && ok_a && ok_b && ok_d;

    // Two operands naming the same port merge into one enable bit,
    // so that port pops a single word
    assign rden_next = ((is_io_a ? port_mask_t'(1) << port_a : '0)
                      | (is_io_b ? port_mask_t'(1) << port_b : '0));

    // ----------------------------------------------------------------------
    // Stage registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pred_valid <= 1'b0;
            pred_ready <= 1'b0;
            io_rden    <= '0;
        end else begin
            pred_valid <= instr_valid;
            pred_ready <= ready;
            io_rden    <= ready ? rden_next : '0;
        end
    end

    always_ff @(posedge clock) begin
        pred_is_io_a     <= is_io_a;
        pred_is_io_b     <= is_io_b;
        pred_write_io    <= is_io_d;
        pred_opcode      <= opcode;
        pred_read_addr_a <= read_addr_a;
        pred_read_addr_b <= read_addr_b;
        pred_write_addr  <= write_addr_d;
    end

    // An annulled instruction must never pop a port
    assert property (@(posedge clock) disable iff (!rst_n)
        (io_rden != '0) |-> pred_ready)
        else $error("io_rden raised for an annulled instruction");

endmodule

// ==== operand_memory.sv ====
// Operand memory: 64-word register memory with two registered read ports and one write port
`include "dp_cfg.svh"

module operand_memory
    import dp_types_pkg::*;
(
    input  logic  clock,
    input  addr_t read_addr_a,
    input  addr_t read_addr_b,
    input  logic  wb_en,
    input  addr_t wb_addr,
    input  word_t wb_data,
    output word_t mem_data_a,
    output word_t mem_data_b
);

    localparam int    MEM_DEPTH = 1 << `DP_ADDR_WIDTH;
    localparam addr_t IO_BASE   = addr_t'(`DP_IO_BASE_ADDR);

    // ----------------------------------------------------------------------
    // Storage
    // ----------------------------------------------------------------------

    // One shared array serves both operands. Locations 0 and the I/O
    // range are never written, so whatever they hold is don't-care
    word_t mem [MEM_DEPTH];

    // ----------------------------------------------------------------------
    // Read path
    // ----------------------------------------------------------------------

    // Address 0 is the null location. A read that coincides with the
    // write of the same location returns the new word, so an instruction
    // issued two cycles after its writer already sees the result
    function automatic word_t read_word(input addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (wb_en && (wb_addr == addr)) begin
            value = wb_data;
        end else begin
            value = mem[addr];
        end
        return value;
    endfunction

    always_ff @(posedge clock) begin
        mem_data_a <= read_word(read_addr_a);
        mem_data_b <= read_word(read_addr_b);
    end

    // ----------------------------------------------------------------------
    // Write path
    // ----------------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (wb_en) begin
            mem[wb_addr] <= wb_data;
        end
    end

    // The writeback stage must route null and I/O destinations elsewhere
    assert property (@(posedge clock)
        wb_en |-> ((wb_addr != '0) && (wb_addr < IO_BASE)))
        else $error("memory write to reserved address %0d", wb_addr);

endmodule

// ==== alu_writeback.sv ====
// ALU and writeback: operand select, result compute, and memory or I/O writeback
`include "dp_cfg.svh"

module alu_writeback
    import dp_types_pkg::*, dp_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       pred_valid,
    input  logic       pred_ready,
    input  logic       pred_is_io_a,
    input  logic       pred_is_io_b,
    input  logic       pred_write_io,
    input  opcode_t    pred_opcode,
    input  addr_t      pred_read_addr_a,
    input  addr_t      pred_read_addr_b,
    input  addr_t      pred_write_addr,
    input  port_mask_t io_rden,
    input  word_t      mem_data_a,
    input  word_t      mem_data_b,
    input  word_t      io_read_data [`DP_IO_PORT_COUNT],
    output logic       wb_en,
    output addr_t      wb_addr,
    output word_t      wb_data,
    output port_mask_t io_wren,
    output word_t      io_write_data,
    output word_t      result,
    output logic       result_valid,
    output logic       annulled
);

    localparam int    PORT_IDX_W = $clog2(`DP_IO_PORT_COUNT);
    localparam addr_t IO_BASE    = addr_t'(`DP_IO_BASE_ADDR);

    // ----------------------------------------------------------------------
    // Operand select
    // ----------------------------------------------------------------------

    addr_t                 offs_a, offs_b, offs_d;
    logic [PORT_IDX_W-1:0] port_a, port_b, port_d;
    word_t                 op_a, op_b, alu_out;

    assign offs_a = pred_read_addr_a - IO_BASE;
    assign offs_b = pred_read_addr_b - IO_BASE;
    assign offs_d = pred_write_addr - IO_BASE;
    assign port_a = offs_a[PORT_IDX_W-1:0];
    assign port_b = offs_b[PORT_IDX_W-1:0];
    assign port_d = offs_d[PORT_IDX_W-1:0];

    // The port head word stands in for whatever the memory returned
    assign op_a = pred_is_io_a ? io_read_data[port_a] : mem_data_a;
    assign op_b = pred_is_io_b ? io_read_data[port_b] : mem_data_b;

    // ----------------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------------

    always_comb begin
        case (pred_opcode)
            OP_ADD:    alu_out = op_a + op_b;
            OP_SUB:    alu_out = op_a - op_b;
            OP_AND:    alu_out = op_a & op_b;
            OP_OR:     alu_out = op_a | op_b;
            OP_XOR:    alu_out = op_a ^ op_b;
            OP_PASS_A: alu_out = op_a;
            default:   alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Writeback
    // ----------------------------------------------------------------------

    // Control state; an annulled instruction leaves only its flag behind
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
            annulled     <= 1'b0;
            wb_en        <= 1'b0;
            io_wren      <= '0;
        end else begin
            result_valid <= pred_ready;
            annulled     <= pred_valid && !pred_ready;
            wb_en        <= pred_ready && !pred_write_io && (pred_write_addr != '0);
            io_wren      <= (pred_ready && pred_write_io) ? port_mask_t'(1) << port_d : '0;
        end
    end

    always_ff @(posedge clock) begin
        result  <= alu_out;
        wb_addr <= pred_write_addr;
    end

    // Memory and port see the same registered word as the result
    assign wb_data       = result;
    assign io_write_data = result;

    assert property (@(posedge clock) disable iff (!rst_n) $onehot0(io_wren))
        else $error("more than one io_wren bit set: %b", io_wren);

    // Any I/O operand consumed by the ALU must be popped from its port
    assert property (@(posedge clock) disable iff (!rst_n)
        pred_ready |-> ((!pred_is_io_a || io_rden[port_a])
                     && (!pred_is_io_b || io_rden[port_b])))
        else $error("I/O operand used without a matching io_rden bit");

endmodule

// ==== datapath_top.sv ====
// Datapath top level: I/O predication, operand memory and ALU writeback stage
`include "dp_cfg.svh"

module datapath_top
    import dp_types_pkg::*, dp_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       rst_n,
    input  logic       instr_valid,
    input  opcode_t    opcode,
    input  addr_t      read_addr_a,
    input  addr_t      read_addr_b,
    input  addr_t      write_addr_d,
    input  logic       cancel,
    input  port_mask_t io_read_ef,
    input  port_mask_t io_write_ef,
    input  word_t      io_read_data [`DP_IO_PORT_COUNT],
    output port_mask_t io_rden,
    output port_mask_t io_wren,
    output word_t      io_write_data,
    output word_t      result,
    output logic       result_valid,
    output logic       annulled
);

    // ----------------------------------------------------------------------
    // Stage 1 to stage 2 wiring
    // ----------------------------------------------------------------------

    logic    pred_valid, pred_ready;
    logic    pred_is_io_a, pred_is_io_b, pred_write_io;
    opcode_t pred_opcode;
    addr_t   pred_read_addr_a, pred_read_addr_b, pred_write_addr;
    word_t   mem_data_a, mem_data_b;

    // Memory write port, fed back from the writeback stage
    logic    wb_en;
    addr_t   wb_addr;
    word_t   wb_data;

    io_predication u_pred (
        .clock, .rst_n, .instr_valid, .cancel, .opcode,
        .read_addr_a, .read_addr_b, .write_addr_d,
        .io_read_ef, .io_write_ef,
        .pred_valid, .pred_ready, .pred_is_io_a, .pred_is_io_b, .pred_write_io,
        .pred_opcode, .pred_read_addr_a, .pred_read_addr_b, .pred_write_addr,
        .io_rden
    );

    // Memory reads run alongside predication and are ready in cycle 1
    operand_memory u_mem (
        .clock, .read_addr_a, .read_addr_b,
        .wb_en, .wb_addr, .wb_data,
        .mem_data_a, .mem_data_b
    );

    alu_writeback u_alu (
        .clock, .rst_n,
        .pred_valid, .pred_ready, .pred_is_io_a, .pred_is_io_b, .pred_write_io,
        .pred_opcode, .pred_read_addr_a, .pred_read_addr_b, .pred_write_addr,
        .io_rden, .mem_data_a, .mem_data_b, .io_read_data,
        .wb_en, .wb_addr, .wb_data,
        .io_wren, .io_write_data, .result, .result_valid, .annulled
    );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset generator: free-running clock and an active-low reset pulse
module tb_clock_gen #(
    parameter int CLOCK_PERIOD = 8,
    parameter int RESET_CYCLES = 16
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Reset lets go on a falling edge, well clear of the sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// ==== tb_datapath.sv ====
// Datapath testbench: I/O port model, reference model, directed tests, watchdog and summary
`include "dp_cfg.svh"

module tb_datapath
    import dp_types_pkg::*, dp_ctrl_pkg::*;
;

    localparam int PORTS           = `DP_IO_PORT_COUNT;
    localparam int IO_BASE         = `DP_IO_BASE_ADDR;
    localparam int CLOCK_PERIOD    = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int TEST_CYCLES     = 90;
    localparam int WATCHDOG_MARGIN = 200;

    logic       clock, rst_n, instr_valid, cancel, result_valid, annulled;
    opcode_t    opcode;
    addr_t      read_addr_a, read_addr_b, write_addr_d;
    port_mask_t io_read_ef, io_write_ef, io_rden, io_wren, rden_seen;
    word_t      io_read_data [PORTS];
    word_t      io_write_data, result;

    // Expected outputs of one instruction, kept for two cycles
    typedef struct packed {
        logic       valid_out;
        logic       annul;
        word_t      value;
        port_mask_t rden;
        port_mask_t wren;
        logic       mem_write;
        addr_t      addr;
    } expect_t;

    expect_t pipe [2];
    word_t   port_q [PORTS][$];
    word_t   port_written [PORTS][$];
    int      port_space [PORTS];
    word_t   ref_mem [1 << `DP_ADDR_WIDTH];
    word_t   ref_q [PORTS][$];
    int      ref_space [PORTS];
    int      seed = 40303;
    int      checks = 0;
    int      errors = 0;
    int      test_start_errors = 0;

    tb_clock_gen #(.CLOCK_PERIOD(CLOCK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clock, .rst_n
    );

    datapath_top u_dut (
        .clock, .rst_n, .instr_valid, .opcode, .read_addr_a, .read_addr_b, .write_addr_d,
        .cancel, .io_read_ef, .io_write_ef, .io_read_data, .io_rden, .io_wren,
        .io_write_data, .result, .result_valid, .annulled
    );

    // ------------------------------------------------------------------
    // I/O port model
    // ------------------------------------------------------------------

    function automatic void update_flags();
        int p;
        for (p = 0; p < PORTS; p++) begin
            io_read_ef[p]   = (port_q[p].size() > 0);
            io_write_ef[p]  = (port_space[p] > 0);
            io_read_data[p] = (port_q[p].size() > 0) ? port_q[p][0] : '0;
        end
    endfunction

    // A read enable seen at one edge pops the head word a cycle later
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rden_seen <= '0;
        end else begin
            rden_seen <= io_rden;
        end
    end

    always @(negedge clock) begin
        for (int p = 0; p < PORTS; p++) begin
            if (rden_seen[p] && (port_q[p].size() > 0)) begin
                void'(port_q[p].pop_front());
            end
            if (io_wren[p]) begin
                port_written[p].push_back(io_write_data);
                port_space[p] = port_space[p] - 1;
            end
        end
        update_flags();
    end

    task automatic load_port(input int p, input word_t w);
        port_q[p].push_back(w);
        ref_q[p].push_back(w);
        update_flags();
    endtask

    task automatic set_space(input int p, input int n);
        port_space[p] = n;
        ref_space[p]  = n;
        update_flags();
    endtask

    // ------------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------------

    function automatic logic is_io(input addr_t a);
        return (int'(a) >= IO_BASE);
    endfunction

    function automatic int port_of(input addr_t a);
        return int'(a) - IO_BASE;
    endfunction

    function automatic logic operand_ready(input addr_t a);
        return !is_io(a) || (ref_q[port_of(a)].size() > 0);
    endfunction

    function automatic word_t operand_value(input addr_t a);
        if (a == '0) begin
            return '0;
        end else if (is_io(a)) begin
            return (ref_q[port_of(a)].size() > 0) ? ref_q[port_of(a)][0] : '0;
        end
        return ref_mem[a];
    endfunction

    // Arithmetic wraps at 16 bits through the word_t return type
    function automatic word_t expected_alu(input opcode_t op, input word_t a, input word_t b);
        case (op)
            OP_ADD:    return a + b;
            OP_SUB:    return a - b;
            OP_AND:    return a & b;
            OP_OR:     return a | b;
            OP_XOR:    return a ^ b;
            OP_PASS_A: return a;
            default:   return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Instruction driver
    // ------------------------------------------------------------------

    task automatic step(input logic valid, input opcode_t op, input addr_t a, input addr_t b,
                        input addr_t d, input logic kill);
        expect_t e;
        word_t   va;
        word_t   vb;
        int      p;
        @(negedge clock);
        // io_rden belongs to the previous instruction, the rest to the one before
        check_value("io_rden", pipe[0].rden, io_rden);
        check_value("result_valid", pipe[1].valid_out, result_valid);
        check_value("annulled", pipe[1].annul, annulled);
        check_value("io_wren", pipe[1].wren, io_wren);
        if (pipe[1].valid_out) begin
            check_value("result", pipe[1].value, result);
        end
        if (pipe[1].wren != '0) begin
            check_value("io_write_data", pipe[1].value, io_write_data);
        end
        // The memory write lands at the coming edge, where the new reader samples
        if (pipe[1].mem_write) begin
            ref_mem[pipe[1].addr] = pipe[1].value;
        end
        va          = operand_value(a);
        vb          = operand_value(b);
        e           = '0;
        e.valid_out = valid && !kill && operand_ready(a) && operand_ready(b)
                      && (!is_io(d) || (ref_space[port_of(d)] > 0));
        e.annul     = valid && !e.valid_out;
        e.value     = expected_alu(op, va, vb);
        e.mem_write = e.valid_out && !is_io(d) && (d != '0);
        e.addr      = d;
        if (e.valid_out) begin
            if (is_io(a)) begin
                e.rden[port_of(a)] = 1'b1;
            end
            if (is_io(b)) begin
                e.rden[port_of(b)] = 1'b1;
            end
            for (p = 0; p < PORTS; p++) begin
                if (e.rden[p]) begin
                    void'(ref_q[p].pop_front());
                end
            end
            if (is_io(d)) begin
                e.wren[port_of(d)] = 1'b1;
                ref_space[port_of(d)]--;
            end
        end
        pipe[1]      = pipe[0];
        pipe[0]      = e;
        instr_valid  = valid;
        cancel       = kill;
        opcode       = op;
        read_addr_a  = a;
        read_addr_b  = b;
        write_addr_d = d;
    endtask

    task automatic issue(input opcode_t op, input addr_t a, input addr_t b, input addr_t d);
        step(1'b1, op, a, b, d, 1'b0);
    endtask

    task automatic idle();
        step(1'b0, OP_ADD, '0, '0, '0, 1'b0);
    endtask

    task automatic flush();
        repeat (3) idle();
    endtask

    // Goes through port 0, so the next port read must wait a cycle
    task automatic load_mem(input addr_t addr, input word_t w);
        load_port(0, w);
        issue(OP_PASS_A, addr_t'(IO_BASE), '0, addr);
        idle();
    endtask

    task automatic report(input string name);
        if (errors == test_start_errors) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // ------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------

    task automatic test_reset_and_load();
        check_value("result_valid", 0, result_valid);
        check_value("annulled", 0, annulled);
        check_value("io_rden", 0, io_rden);
        check_value("io_wren", 0, io_wren);
        check_value("wb_en", 0, u_dut.wb_en);
        load_mem(5, word_t'($random(seed)));
        load_mem(6, word_t'($random(seed)));
        issue(OP_PASS_A, 5, 0, 0);
        issue(OP_PASS_A, 6, 0, 0);
        flush();
        report("reset_and_load");
    endtask

    task automatic test_opcodes();
        opcode_t ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_PASS_A};
        load_mem(10, word_t'($random(seed)));
        load_mem(11, word_t'($random(seed)));
        foreach (ops[i]) begin
            issue(ops[i], 10, 11, addr_t'(25 + i));
        end
        flush();
        report("opcodes");
    endtask

    task automatic test_not_ready();
        load_mem(12, word_t'($random(seed)));
        load_port(1, word_t'($random(seed)));
        set_space(3, 0);
        issue(OP_ADD, 62, 12, 13);
        issue(OP_PASS_A, 61, 0, 63);
        issue(OP_PASS_A, 62, 0, 12);
        issue(OP_PASS_A, 61, 0, 0);
        idle();
        issue(OP_PASS_A, 12, 0, 0);
        flush();
        check_value("port 3 write count", 0, port_written[3].size());
        set_space(3, 4);
        report("not_ready");
    endtask

    task automatic test_cancel();
        load_mem(14, word_t'($random(seed)));
        load_port(1, word_t'($random(seed)));
        step(1'b1, OP_PASS_A, 61, 0, 14, 1'b1);
        step(1'b1, OP_ADD, 14, 14, 62, 1'b1);
        issue(OP_PASS_A, 61, 0, 0);
        issue(OP_PASS_A, 14, 0, 0);
        flush();
        check_value("port 2 write count", 0, port_written[2].size());
        report("cancel");
    endtask

    task automatic test_io_write();
        word_t a;
        word_t b;
        a = word_t'($random(seed));
        b = word_t'($random(seed));
        load_mem(16, a);
        load_mem(17, b);
        issue(OP_ADD, 16, 17, 62);
        issue(OP_XOR, 16, 17, 0);
        issue(OP_OR, 0, 0, 0);
        flush();
        check_value("port 2 write count", 1, port_written[2].size());
        if (port_written[2].size() > 0) begin
            check_value("port 2 written word", expected_alu(OP_ADD, a, b), port_written[2][0]);
        end
        report("io_write");
    endtask

    task automatic test_back_to_back();
        load_mem(20, word_t'($random(seed)));
        load_mem(21, word_t'($random(seed)));
        load_mem(22, word_t'($random(seed)));
        issue(OP_ADD, 20, 21, 22);
        // One cycle behind the writer still reads the old word
        issue(OP_PASS_A, 22, 0, 0);
        issue(OP_PASS_A, 22, 0, 0);
        issue(OP_SUB, 20, 21, 23);
        issue(OP_AND, 20, 22, 24);
        issue(OP_PASS_A, 23, 0, 0);
        issue(OP_XOR, 24, 23, 0);
        flush();
        report("back_to_back");
    endtask

    // ------------------------------------------------------------------
    // Run control
    // ------------------------------------------------------------------

    initial begin
        instr_valid  = 1'b0;
        cancel       = 1'b0;
        opcode       = OP_ADD;
        read_addr_a  = '0;
        read_addr_b  = '0;
        write_addr_d = '0;
        pipe[0]      = '0;
        pipe[1]      = '0;
        for (int p = 0; p < PORTS; p++) begin
            set_space(p, 4);
        end
        wait (rst_n === 1'b1);
        test_reset_and_load();
        test_opcodes();
        test_not_ready();
        test_cancel();
        test_io_write();
        test_back_to_back();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((RESET_CYCLES + TEST_CYCLES) * CLOCK_PERIOD + WATCHDOG_MARGIN);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+.
dp_types_pkg.sv
dp_ctrl_pkg.sv
io_predication.sv
operand_memory.sv
alu_writeback.sv
datapath_top.sv
tb_clock_gen.sv
tb_datapath.sv

// ==== Bender.yml ====
package:
  name: operand_datapath

export_include_dirs:
  - .

sources:
  # Design sources in compile order
  - dp_types_pkg.sv
  - dp_ctrl_pkg.sv
  - io_predication.sv
  - operand_memory.sv
  - alu_writeback.sv
  - datapath_top.sv
  # Testbench
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_datapath.sv
